//--- common/ciPkg.sv
package ciPkg;

  // Custom instruction numbers as the processor issues them
  typedef enum logic [7:0] {
    byteSwapId  = 8'd1,
    delayId     = 8'd6,
    profileId   = 8'd8,
    grayscaleId = 8'd12
  } ciId_e;

  typedef struct packed {
    logic        start;  // One-cycle pulse
    ciId_e       id;
    logic [31:0] dataA;
    logic [31:0] dataB;
  } ciReq_t;

  // All zero unless the unit is reporting done
  typedef struct packed {
    logic        done;
    logic [31:0] result;
  } ciResp_t;

  // Counter selector in dataA[1:0], value 3 reads as zero
  typedef enum logic [1:0] {
    cycleCount = 2'd0,
    stallCount = 2'd1,
    idleCount  = 2'd2
  } profCounter_e;

  localparam int profCounterNum = 3;

  // Field positions inside dataB of a profile instruction
  localparam int profEnableLsb = 0;
  localparam int profClearLsb  = 4;

  // Luma weights, scaled by 256
  localparam logic [15:0] grayRedWeight   = 16'd54;
  localparam logic [15:0] grayGreenWeight = 16'd183;
  localparam logic [15:0] grayBlueWeight  = 16'd19;

endpackage

//--- common/socCfgPkg.sv
package socCfgPkg;

  localparam int systemClockHz        = 50_000_000;
  localparam int cyclesPerMicrosecond = systemClockHz / 1_000_000;

  // Reset releases when the top bit sets, 16 clocks after lock
  localparam int resetCountWidth = 5;

  localparam int delayCountWidth = 32;

  typedef enum logic {
    delayIdle     = 1'b0,
    delayCounting = 1'b1
  } delayState_e;

endpackage

//--- hw/resetSequencer.sv
module resetSequencer
  import socCfgPkg::*;
(
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReset,
  output logic resetReleasedN
);

  logic [resetCountWidth-1:0] resetCount;
  logic                       released;

  assign released = resetCount[resetCountWidth-1];

  // Losing lock clears at once, counter then saturates on the top bit
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) resetCount <= '0;
    else if (!released) resetCount <= resetCount + 1'b1;
  end

  assign resetReleasedN = released;
  assign coreReset      = ~released;  // Active high for the units

  countNeverDecreases: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    resetCount >= $past(resetCount)
  );

endmodule

//--- ciUnits/pixelByteOps.sv
module pixelByteOps
  import ciPkg::*;
(
  input  ciReq_t  ciRequest,
  output ciResp_t ciResponse
);

  logic        swapStart;
  logic        grayStart;
  logic [31:0] swapped;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  logic [7:0]  grayValue;

  assign swapStart = ciRequest.start && (ciRequest.id == byteSwapId);
  assign grayStart = ciRequest.start && (ciRequest.id == grayscaleId);

  assign swapped = {ciRequest.dataA[7:0],   ciRequest.dataA[15:8],
                    ciRequest.dataA[23:16], ciRequest.dataA[31:24]};

  // RGB565 channels widened to 8 bits
  assign red   = {ciRequest.dataA[15:11], 3'b000};
  assign green = {ciRequest.dataA[10:5],  2'b00};
  assign blue  = {ciRequest.dataA[4:0],   3'b000};

  // Fits in 16 bits even for white
  assign weightedSum = red * grayRedWeight
                     + green * grayGreenWeight
                     + blue * grayBlueWeight;

  assign grayValue = weightedSum[15:8];  // Divide by 256

  always_comb begin
    ciResponse = '0;
    if (swapStart) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = swapped;
    end else if (grayStart) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = {24'd0, grayValue};
    end
  end

endmodule

//--- ciUnits/profileCounters.sv
module profileCounters
  import ciPkg::*;
(
  input  logic    s_systemClock,
  input  logic    coreReset,
  input  ciReq_t  ciRequest,
  input  logic    stall,
  input  logic    busIdle,
  output ciResp_t ciResponse
);

  logic [profCounterNum-1:0] enableReg;
  logic [profCounterNum-1:0] countCondition;
  logic [profCounterNum-1:0] clearMask;
  logic [31:0]               counterValue [profCounterNum];
  logic                      profStart;
  logic [31:0]               readValue;

  assign profStart = ciRequest.start && (ciRequest.id == profileId);
  assign clearMask = profStart ? ciRequest.dataB[profClearLsb +: profCounterNum] : '0;

  always_comb begin
    countCondition             = '0;
    countCondition[cycleCount] = 1'b1;
    countCondition[stallCount] = stall;
    countCondition[idleCount]  = busIdle;
  end

  // New enables apply from the edge that ends the start cycle
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      enableReg <= '0;
    end else if (profStart) begin
      enableReg <= ciRequest.dataB[profEnableLsb +: profCounterNum];
    end
  end

  for (genvar i = 0; i < profCounterNum; i++) begin : counterGen
    always_ff @(posedge s_systemClock or posedge coreReset) begin
      if (coreReset) begin
        counterValue[i] <= '0;
      end else if (clearMask[i]) begin  // Clear wins over counting
        counterValue[i] <= '0;
      end else if (enableReg[i] && countCondition[i]) begin
        counterValue[i] <= counterValue[i] + 32'd1;
      end
    end
  end

  // Read returns the value held before this cycle's edge
  always_comb begin
    case (profCounter_e'(ciRequest.dataA[1:0]))
      cycleCount: readValue = counterValue[cycleCount];
      stallCount: readValue = counterValue[stallCount];
      idleCount:  readValue = counterValue[idleCount];
      default:    readValue = '0;
    endcase
  end

  assign ciResponse.done   = profStart;
  assign ciResponse.result = profStart ? readValue : 32'd0;

endmodule

//--- ciUnits/microDelay.sv
module microDelay
  import ciPkg::*;
  import socCfgPkg::*;
(
  input  logic    s_systemClock,
  input  logic    coreReset,
  input  ciReq_t  ciRequest,
  output ciResp_t ciResponse
);

  delayState_e                stateReg;
  logic [delayCountWidth-1:0] remaining;
  logic [delayCountWidth-1:0] loadValue;
  logic                       delayStart;
  logic                       expired;

  assign delayStart = ciRequest.start && (ciRequest.id == delayId);
  assign expired    = (stateReg == delayCounting) && (remaining == '0);

  // Done lands N cycles after start, so N-1 is loaded; zero acts as one cycle
  assign loadValue = (ciRequest.dataA == '0) ? '0 :
                     delayCountWidth'(ciRequest.dataA * cyclesPerMicrosecond - 1);

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      stateReg <= delayIdle;
    end else begin
      case (stateReg)
        delayIdle:     if (delayStart) stateReg <= delayCounting;
        delayCounting: if (expired) stateReg <= delayIdle;
        default:       stateReg <= delayIdle;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (delayStart) begin
      remaining <= loadValue;
    end else if ((stateReg == delayCounting) && !expired) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign ciResponse.done   = expired;  // Single-cycle pulse
  assign ciResponse.result = 32'd0;

  // Processor blocks until done, so nothing may start mid-count
  noStartWhileCounting: assert property (
    @(posedge s_systemClock) disable iff (coreReset)
    (stateReg == delayCounting) |-> !ciRequest.start
  );

endmodule

//--- hw/ciSubsystem.sv
module ciSubsystem
  import ciPkg::*;
(
  input  logic    s_systemClock,
  input  logic    s_pllLocked,
  input  ciReq_t  ciRequest,
  input  logic    stall,
  input  logic    busIdle,
  output ciResp_t ciResponse,
  output logic    resetReleasedN
);

  logic    coreReset;
  ciResp_t pixelResponse;
  ciResp_t profileResponse;
  ciResp_t delayResponse;

  resetSequencer resetSeq (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .coreReset     (coreReset),
    .resetReleasedN(resetReleasedN)
  );

  pixelByteOps pixelOps (
    .ciRequest (ciRequest),
    .ciResponse(pixelResponse)
  );

  profileCounters profiler (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciRequest    (ciRequest),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciResponse   (profileResponse)
  );

  microDelay delayUnit (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciRequest    (ciRequest),
    .ciResponse   (delayResponse)
  );

  // Idle units drive all zero, so a plain OR merges them
  assign ciResponse = pixelResponse | profileResponse | delayResponse;

  // Blocking handshake means only one unit may answer per cycle
  oneDoneAtATime: assert property (
    @(posedge s_systemClock) disable iff (coreReset)
    $onehot0({pixelResponse.done, profileResponse.done, delayResponse.done})
  );

endmodule

//--- verif/tbClock.sv
module tbClock (
  output logic s_systemClock
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period, first rising edge at 10 ns
  initial begin
    s_systemClock = 1'b0;
    forever begin
      #10 s_systemClock = ~s_systemClock;
    end
  end

endmodule

//--- verif/ciSubsystemTb.sv
module ciSubsystemTb
  import ciPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    string       name;
    logic [7:0]  id;         // Plain byte so unowned ids fit
    logic [31:0] dataA;
    logic [31:0] dataB;
    int          preCycles;  // Activity cycles before the start
    logic [31:0] stallBits;
    logic [31:0] idleBits;
    int          latency;    // Zero for same-cycle units
    ciResp_t     expected;
  } testEntry_t;

  logic       s_systemClock;
  logic       s_pllLocked;
  ciReq_t     request;
  ciResp_t    ciResponse;
  logic       stall;
  logic       busIdle;
  logic       resetReleasedN;
  testEntry_t tests[$];
  logic [31:0] modelCount [3];
  logic [2:0] modelEnable;
  int         errorCount = 0;
  int         passCount = 0;
  int         failCount = 0;
  int         testNumber = 0;
  int         cycleCount = 0;
  int         timeoutLimit = 0;

  tbClock clockGen (.s_systemClock(s_systemClock));

  ciSubsystem i_dut (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciRequest     (request),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciResponse    (ciResponse),
    .resetReleasedN(resetReleasedN)
  );

  function automatic logic [31:0] swapBytes(input logic [31:0] value);
    logic [31:0] reversed;
    for (int b = 0; b < 4; b++) begin
      reversed[8*b +: 8] = value[8*(3-b) +: 8];
    end
    return reversed;
  endfunction

  // Luma weights 54, 183, 19 over 256
  function automatic logic [31:0] grayOf(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return (red * 54 + green * 183 + blue * 19) / 256;
  endfunction

  function automatic logic [31:0] modelRead(input logic [1:0] select);
    if (select == 2'd3) return 32'd0;
    return modelCount[select];
  endfunction

  function automatic void addEntry(input string name, input logic [7:0] id,
                                   input logic [31:0] dataA, input logic [31:0] dataB,
                                   input int preCycles, input int latency,
                                   input logic done, input logic [31:0] result);
    testEntry_t e;
    e.name            = name;
    e.id              = id;
    e.dataA           = dataA;
    e.dataB           = dataB;
    e.preCycles       = preCycles;
    e.stallBits       = $urandom();
    e.idleBits        = $urandom();
    e.latency         = latency;
    e.expected.done   = done;
    e.expected.result = result;
    tests.push_back(e);
  endfunction

  task automatic buildTable();
    logic [31:0] value;
    logic [15:0] pixels [5];
    pixels = '{16'h0000, 16'hFFFF, 16'hF800, 16'h07E0, 16'h001F};  // Black, white, R, G, B
    repeat (4) begin
      value = $urandom();
      addEntry("byte swap", byteSwapId, value, $urandom(), 0, 0, 1'b1, swapBytes(value));
    end
    foreach (pixels[i]) begin
      addEntry("grayscale fixed", grayscaleId, {16'd0, pixels[i]}, 0, 0, 0, 1'b1,
               grayOf(pixels[i]));
    end
    repeat (3) begin
      value = $urandom();
      addEntry("grayscale random", grayscaleId, value, 0, 0, 0, 1'b1, grayOf(value[15:0]));
    end
    // Profile results are filled from the counter model when applied
    addEntry("profile enable and clear", profileId, 0, 32'h77, 0, 0, 1'b1, 0);
    addEntry("profile cycle read", profileId, 0, 32'h07, 12, 0, 1'b1, 0);
    addEntry("profile stall read", profileId, 1, 32'h07, 12, 0, 1'b1, 0);
    addEntry("profile idle read", profileId, 2, 32'h07, 12, 0, 1'b1, 0);
    addEntry("profile selector 3", profileId, 3, 32'h07, 0, 0, 1'b1, 0);
    addEntry("profile clear", profileId, 1, 32'h70, 4, 0, 1'b1, 0);
    addEntry("profile cycle after clear", profileId, 0, 32'h00, 4, 0, 1'b1, 0);
    addEntry("profile stall after clear", profileId, 1, 32'h00, 4, 0, 1'b1, 0);
    addEntry("profile idle after clear", profileId, 2, 32'h00, 4, 0, 1'b1, 0);
    addEntry("delay 0 us", delayId, 0, 0, 0, 1, 1'b1, 0);
    addEntry("delay 1 us", delayId, 1, 0, 0, 50, 1'b1, 0);
    addEntry("delay 3 us", delayId, 3, 0, 0, 150, 1'b1, 0);
    addEntry("unknown id", 8'd3, $urandom(), $urandom(), 0, 0, 1'b0, 0);
  endtask

  task automatic checkResponse(input ciResp_t expected, input ciResp_t actual,
                               input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s, expected done %0b result %h, got done %0b result %h",
               $time, what, expected.done, expected.result, actual.done, actual.result);
    end
  endtask

  task automatic checkReset(input logic expected, input logic actual, input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s, expected %0b, got %0b", $time, what, expected, actual);
    end
  endtask

  task automatic checkLatency(input int expected, input int actual, input string what);
    if (actual != expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s, done after %0d cycles, expected %0d",
               $time, what, actual, expected);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testNumber++;
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("Test %0d (%s) passed", testNumber, name);
    end else begin
      failCount++;
      $display("Test %0d (%s) failed", testNumber, name);
    end
  endtask

  task automatic runResetTest();
    int errorsBefore;
    errorsBefore = errorCount;
    repeat (5) begin  // Lock held low
      @(negedge s_systemClock);
      checkReset(1'b0, resetReleasedN, "released while unlocked");
      checkResponse('0, ciResponse, "response while unlocked");
    end
    s_pllLocked = 1'b1;
    for (int edges = 1; edges <= 20; edges++) begin
      @(negedge s_systemClock);
      checkReset(edges >= 16, resetReleasedN, $sformatf("release after %0d edges", edges));
      if (edges < 16) checkResponse('0, ciResponse, "response before release");
    end
    reportTest("reset release", errorsBefore);
  endtask

  task automatic applyEntry(input int idx);
    testEntry_t e;
    int         errorsBefore;
    int         waited;
    e = tests[idx];
    errorsBefore = errorCount;
    for (int c = 0; c < e.preCycles; c++) begin
      @(negedge s_systemClock);
      stall   = e.stallBits[c % 32];
      busIdle = e.idleBits[c % 32];
    end
    @(negedge s_systemClock);
    stall   = 1'b0;
    busIdle = 1'b0;
    if (e.id == profileId) e.expected.result = modelRead(e.dataA[1:0]);
    request.start = 1'b1;
    request.id    = ciId_e'(e.id);
    request.dataA = e.dataA;
    request.dataB = e.dataB;
    #1;
    if (e.latency > 0) begin
      checkResponse('0, ciResponse, {e.name, " start cycle"});
    end else if (e.expected.done && !ciResponse.done) begin
      errorCount++;
      $display("No done in the start cycle of %s", e.name);
    end else begin
      checkResponse(e.expected, ciResponse, e.name);
    end
    @(negedge s_systemClock);
    request = '0;
    #1;
    if (e.latency == 0) begin
      checkResponse('0, ciResponse, {e.name, " cycle after start"});
    end else begin
      waited = 1;
      while (!ciResponse.done && waited < e.latency + 20) begin
        @(negedge s_systemClock);
        #1;
        waited++;
      end
      if (!ciResponse.done) begin
        errorCount++;
        $display("Delay unit gave no done within %0d cycles (%s)", waited, e.name);
      end else begin
        checkLatency(e.latency, waited, e.name);
        checkResponse(e.expected, ciResponse, {e.name, " done"});
        @(negedge s_systemClock);
        #1;
        checkResponse('0, ciResponse, {e.name, " after done"});  // Single-cycle pulse
      end
    end
    reportTest(e.name, errorsBefore);
  endtask

  // Counter model updated once per rising edge
  always @(posedge s_systemClock) begin : counterModel
    logic [2:0] condition;
    logic       profStart;
    condition = {busIdle, stall, 1'b1};
    profStart = request.start && (request.id == profileId);
    for (int i = 0; i < 3; i++) begin
      if (profStart && request.dataB[4 + i]) modelCount[i] = '0;
      else if (modelEnable[i] && condition[i]) modelCount[i] = modelCount[i] + 32'd1;
    end
    if (profStart) modelEnable = request.dataB[2:0];
  end

  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycleCount);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    s_pllLocked = 1'b0;
    request     = '0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    modelEnable = '0;
    foreach (modelCount[i]) modelCount[i] = '0;
    void'($urandom(32'h3de4));
    buildTable();
    timeoutLimit = 45;  // Lock low, release window and slack
    foreach (tests[i]) timeoutLimit += tests[i].preCycles + tests[i].latency + 20;
    runResetTest();
    foreach (tests[i]) applyEntry(i);
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             testNumber, passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- ciSubsystem.f
common/ciPkg.sv
common/socCfgPkg.sv
hw/resetSequencer.sv
ciUnits/pixelByteOps.sv
ciUnits/profileCounters.sv
ciUnits/microDelay.sv
hw/ciSubsystem.sv
verif/tbClock.sv
verif/ciSubsystemTb.sv
